//--- design/video_pkg.sv
package video_pkg;

  typedef enum logic [1:0] {
    mode_off,
    mode_640x480,
    mode_1024x768,
    mode_1280x720
  } video_mode_e;

  typedef enum logic [0:0] {
    reg_control      = 1'b0,
    reg_graphic_base = 1'b1
  } apb_reg_e;

  localparam int H_W = 11;
  localparam int V_W = 10;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  typedef logic [9:0] tmds_sym_t;

  localparam int LINE_STRIDE_BYTES = 4096;
  localparam int BURST_BYTES = 64;
  localparam int BEAT_W = 64;
  localparam int PIXEL_DELAY = 2;
  localparam int MAX_LINE_WORDS = 320;

  // Packed as {active, sync start, sync end, last}
  function automatic logic [4*H_W-1:0] timing_preset(input video_mode_e mode,
                                                     input logic vertical);
    logic [4*H_W-1:0] preset;
    case (mode)
      mode_640x480:
        preset = vertical ? {11'd480, 11'd490, 11'd492, 11'd524}
                          : {11'd640, 11'd656, 11'd752, 11'd799};
      mode_1024x768:
        preset = vertical ? {11'd768, 11'd771, 11'd777, 11'd805}
                          : {11'd1024, 11'd1048, 11'd1184, 11'd1343};
      mode_1280x720:
        preset = vertical ? {11'd720, 11'd725, 11'd730, 11'd749}
                          : {11'd1280, 11'd1390, 11'd1430, 11'd1649};
      default: preset = '0; // Off, everything collapses to zero
    endcase
    return preset;
  endfunction

endpackage

//--- design/apb_regs.sv
module apb_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [4:0]               paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output video_pkg::video_mode_e   video_mode,
  output logic                     show_graphic,
  output logic [25:0]              graphic_base
);

  video_pkg::apb_reg_e reg_sel;
  logic                reg_hit;
  logic                wr_en;

  assign wr_en = psel & penable & pwrite;

  // Address captured every cycle, so access phase sees the setup address
  always_ff @(posedge clk) begin
    reg_sel <= video_pkg::apb_reg_e'(paddr[2]);
    reg_hit <= paddr[4:3] == 2'b00;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      video_mode   <= video_pkg::mode_off;
      show_graphic <= 1'b0;
    end else if (wr_en && reg_hit && reg_sel == video_pkg::reg_control) begin
      video_mode   <= video_pkg::video_mode_e'(pwdata[1:0]);
      show_graphic <= pwdata[2];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && reg_hit && reg_sel == video_pkg::reg_graphic_base)
      graphic_base <= pwdata[31:6]; // 64-byte aligned
  end

  always_comb begin
    prdata = '0;
    if (reg_hit) begin
      case (reg_sel)
        video_pkg::reg_control:      prdata = {29'd0, show_graphic, video_mode};
        video_pkg::reg_graphic_base: prdata = {graphic_base, 6'd0};
        default:                     prdata = '0;
      endcase
    end
  end

endmodule

//--- design/video_timing.sv
module video_timing (
  input  logic                        clk,
  input  logic                        reset,
  input  video_pkg::video_mode_e      video_mode,
  output logic [video_pkg::H_W-1:0]   h_count,
  output logic [video_pkg::V_W-1:0]   v_count,
  output logic                        de,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        line_start,
  output logic [video_pkg::V_W-1:0]   fetch_line,
  output logic                        fetch_valid
);

  localparam int H_W = video_pkg::H_W;
  localparam int V_W = video_pkg::V_W;
  localparam int DLY = video_pkg::PIXEL_DELAY;

  video_pkg::video_mode_e cur_mode;
  logic [4*H_W-1:0]       h_preset;
  logic [4*H_W-1:0]       v_preset;
  logic [H_W-1:0]         h_act, h_ss, h_se, h_last;
  logic [V_W-1:0]         v_act, v_ss, v_se, v_last;
  logic                   running;
  logic                   last_line;
  logic                   de_raw, hs_raw, vs_raw;
  logic [DLY-1:0][2:0]    ctl_pipe;

  assign h_preset = video_pkg::timing_preset(cur_mode, 1'b0);
  assign v_preset = video_pkg::timing_preset(cur_mode, 1'b1);

  assign h_act  = h_preset[3*H_W +: H_W];
  assign h_ss   = h_preset[2*H_W +: H_W];
  assign h_se   = h_preset[H_W +: H_W];
  assign h_last = h_preset[0 +: H_W];
  assign v_act  = v_preset[3*H_W +: V_W];
  assign v_ss   = v_preset[2*H_W +: V_W];
  assign v_se   = v_preset[H_W +: V_W];
  assign v_last = v_preset[0 +: V_W];

  assign running   = cur_mode != video_pkg::mode_off;
  assign last_line = v_count == v_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_mode <= video_pkg::mode_off;
      h_count  <= '0;
      v_count  <= '0;
    end else if (!running) begin
      cur_mode <= video_mode; // Idle sits at a frame start
      h_count  <= '0;
      v_count  <= '0;
    end else if (h_count == h_last) begin
      h_count <= '0;
      if (last_line) begin
        v_count  <= '0;
        cur_mode <= video_mode;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign de_raw = running && h_count < h_act && v_count < v_act;
  assign hs_raw = running && h_count >= h_ss && h_count < h_se;
  assign vs_raw = running && v_count >= v_ss && v_count < v_se;

  // Match the pixel pipeline latency
  always_ff @(posedge clk) begin
    if (reset)
      ctl_pipe <= '0;
    else
      ctl_pipe <= {ctl_pipe[DLY-2:0], {de_raw, hs_raw, vs_raw}};
  end

  assign {de, hsync, vsync} = ctl_pipe[DLY-1];

  assign line_start  = running && h_count == h_act;
  assign fetch_line  = last_line ? '0 : v_count + 1'b1;
  assign fetch_valid = running && (last_line || (v_count + 1'b1) < v_act);

endmodule

//--- design/line_fetch.sv
module line_fetch #(
  parameter int LINE_BUF_DEPTH  = 512,
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          show_graphic,
  input  logic [25:0]                   graphic_base,
  input  video_pkg::video_mode_e        video_mode,
  input  logic                          line_start,
  input  logic [video_pkg::V_W-1:0]     fetch_line,
  input  logic                          fetch_valid,
  output logic                          a_valid,
  output logic [1:0]                    a_source,
  output logic [31:0]                   a_address,
  input  logic                          a_ready,
  input  logic                          d_valid,
  input  logic [1:0]                    d_source,
  input  logic [video_pkg::BEAT_W-1:0]  d_data,
  input  logic                          rd_bank,
  input  logic [video_pkg::H_W-3:0]     rd_addr,
  output logic [video_pkg::BEAT_W-1:0]  rd_data
);

  localparam int H_W = video_pkg::H_W;
  localparam int ADDR_W = $clog2(LINE_BUF_DEPTH);
  localparam int BEATS = video_pkg::BURST_BYTES * 8 / video_pkg::BEAT_W;
  localparam int BEAT_IDX_W = $clog2(BEATS);
  localparam int BURST_CNT_W = $clog2(video_pkg::MAX_LINE_WORDS / BEATS + 1);
  localparam int PIX_PER_BURST = video_pkg::BURST_BYTES / 2;
  localparam int NUM_SRC = 4;
  localparam int OPEN_W = $clog2(MAX_OUTSTANDING + 1);

  typedef enum logic [1:0] {st_idle, st_request, st_drain} state_e;

  state_e                 state;
  logic [4*H_W-1:0]       h_preset;
  logic [BURST_CNT_W-1:0] line_bursts, burst_total, issued, done;
  logic                   wr_bank;
  logic [NUM_SRC-1:0]     src_busy;
  logic [BURST_CNT_W-1:0] src_burst [NUM_SRC];
  logic [BEAT_IDX_W-1:0]  src_beat [NUM_SRC];
  logic [OPEN_W-1:0]      open_count;
  logic                   issue, last_beat, can_issue;
  logic [ADDR_W-1:0]      wr_word;
  logic [video_pkg::BEAT_W-1:0] line_buf [2*LINE_BUF_DEPTH];

  assign h_preset    = video_pkg::timing_preset(video_mode, 1'b0);
  assign line_bursts = BURST_CNT_W'(h_preset[3*H_W +: H_W] / PIX_PER_BURST);

  assign issue     = a_valid & a_ready;
  assign last_beat = d_valid && src_beat[d_source] == BEAT_IDX_W'(BEATS - 1);
  assign can_issue = open_count < OPEN_W'(MAX_OUTSTANDING) && !src_busy[a_source];
  assign wr_word   = ADDR_W'({src_burst[d_source], src_beat[d_source]}); // Burst slot + beat

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      a_valid    <= 1'b0;
      src_busy   <= '0;
      open_count <= '0;
      issued     <= '0;
      done       <= '0;
      for (int s = 0; s < NUM_SRC; s++)
        src_beat[s] <= '0;
    end else begin
      case (state)
        st_idle:
          if (line_start && fetch_valid && show_graphic && line_bursts != '0) begin
            state       <= st_request;
            burst_total <= line_bursts;
            issued      <= '0;
            done        <= '0;
            wr_bank     <= fetch_line[0];
            a_source    <= '0;
            a_address   <= {graphic_base, 6'd0} +
                           32'(fetch_line) * video_pkg::LINE_STRIDE_BYTES;
          end
        st_request:
          if (!a_valid) begin
            a_valid <= can_issue;
          end else if (a_ready) begin
            a_valid   <= 1'b0;
            a_address <= a_address + video_pkg::BURST_BYTES;
            a_source  <= a_source + 1'b1;
            issued    <= issued + 1'b1;
            if (issued == burst_total - 1'b1)
              state <= st_drain;
          end
        st_drain:
          if (last_beat && done == burst_total - 1'b1)
            state <= st_idle; // Last beat of the line written
        default: state <= st_idle;
      endcase

      if (issue) begin
        src_busy[a_source] <= 1'b1;
        src_beat[a_source] <= '0;
      end
      if (d_valid)
        src_beat[d_source] <= src_beat[d_source] + 1'b1;
      if (last_beat) begin
        src_busy[d_source] <= 1'b0;
        done               <= done + 1'b1;
      end
      open_count <= open_count + OPEN_W'(issue) - OPEN_W'(last_beat);
    end
  end

  always_ff @(posedge clk) begin
    if (issue)
      src_burst[a_source] <= issued;
    if (d_valid)
      line_buf[{wr_bank, wr_word}] <= d_data;
    rd_data <= line_buf[{rd_bank, ADDR_W'(rd_addr)}];
  end

endmodule

//--- design/pixel_pipe.sv
module pixel_pipe (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [video_pkg::H_W-1:0]     h_count,
  input  logic [video_pkg::V_W-1:0]     v_count,
  input  logic                          show_graphic,
  output logic                          rd_bank,
  output logic [video_pkg::H_W-3:0]     rd_addr,
  input  logic [video_pkg::BEAT_W-1:0]  rd_data,
  output video_pkg::rgb888_t            color
);

  logic [1:0]         lane_q;
  logic               show_q;
  video_pkg::rgb565_t pix;

  // Four pixels per beat, lowest pixel in the low bits
  assign rd_bank = v_count[0];
  assign rd_addr = h_count[video_pkg::H_W-1:2];

  always_ff @(posedge clk) begin
    if (reset)
      show_q <= 1'b0;
    else
      show_q <= show_graphic;
    lane_q <= h_count[1:0]; // Follows the buffer read
  end

  assign pix = video_pkg::rgb565_t'(rd_data[{lane_q, 4'b0000} +: 16]);

  always_ff @(posedge clk) begin
    if (!show_q) begin
      color <= '0;
    end else begin
      color.red   <= {pix.red, pix.red[4:2]};
      color.green <= {pix.green, pix.green[5:4]};
      color.blue  <= {pix.blue, pix.blue[4:2]};
    end
  end

endmodule

//--- design/tmds_encoder.sv
module tmds_encoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           data,
  input  logic [1:0]           ctrl,
  input  logic                 de,
  output video_pkg::tmds_sym_t sym
);

  localparam video_pkg::tmds_sym_t CTRL_00 = 10'b1101010100;
  localparam video_pkg::tmds_sym_t CTRL_01 = 10'b0010101011;
  localparam video_pkg::tmds_sym_t CTRL_10 = 10'b0101010100;
  localparam video_pkg::tmds_sym_t CTRL_11 = 10'b1010101011;

  logic [3:0]           n1_data, n1_qm, n0_qm;
  logic                 use_xnor;
  logic [8:0]           q_m;
  logic signed [5:0]    disp, disp_next, balance;
  video_pkg::tmds_sym_t data_sym, ctrl_sym, sym_q;

  always_comb begin
    n1_data  = 4'($countones(data));
    use_xnor = n1_data > 4'd4 || (n1_data == 4'd4 && !data[0]);
    q_m[0]   = data[0];
    for (int i = 1; i < 8; i++)
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : q_m[i-1] ^ data[i];
    q_m[8]   = ~use_xnor;
    n1_qm    = 4'($countones(q_m[7:0]));
    n0_qm    = 4'd8 - n1_qm;
    balance  = $signed({2'b00, n1_qm}) - $signed({2'b00, n0_qm}); // Ones minus zeros

    if (disp == 0 || balance == 0) begin
      data_sym  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      disp_next = q_m[8] ? disp + balance : disp - balance;
    end else if (disp[5] == balance[5]) begin
      // Same sign, invert to pull back toward zero
      data_sym  = {1'b1, q_m[8], ~q_m[7:0]};
      disp_next = disp - balance + (q_m[8] ? 6'sd2 : 6'sd0);
    end else begin
      data_sym  = {1'b0, q_m[8], q_m[7:0]};
      disp_next = disp + balance - (q_m[8] ? 6'sd0 : 6'sd2);
    end

    case (ctrl)
      2'b00:   ctrl_sym = CTRL_00;
      2'b01:   ctrl_sym = CTRL_01;
      2'b10:   ctrl_sym = CTRL_10;
      default: ctrl_sym = CTRL_11;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sym_q <= CTRL_00;
      sym   <= CTRL_00;
      disp  <= '0;
    end else begin
      sym_q <= de ? data_sym : ctrl_sym;
      sym   <= sym_q;
      disp  <= de ? disp_next : 6'sd0; // Balance restarts each blanking
    end
  end

endmodule

//--- design/video_top.sv
module video_top #(
  parameter int LINE_BUF_DEPTH  = 512,
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [4:0]                    paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          a_valid,
  input  logic                          a_ready,
  output logic [1:0]                    a_source,
  output logic [31:0]                   a_address,
  input  logic                          d_valid,
  input  logic [1:0]                    d_source,
  input  logic [video_pkg::BEAT_W-1:0]  d_data,
  output video_pkg::tmds_sym_t          tmds_red,
  output video_pkg::tmds_sym_t          tmds_green,
  output video_pkg::tmds_sym_t          tmds_blue,
  output video_pkg::video_mode_e        video_mode_out
);

  video_pkg::video_mode_e        video_mode;
  logic                          show_graphic;
  logic [25:0]                   graphic_base;
  logic [video_pkg::H_W-1:0]     h_count;
  logic [video_pkg::V_W-1:0]     v_count;
  logic                          de, hsync, vsync;
  logic                          line_start;
  logic [video_pkg::V_W-1:0]     fetch_line;
  logic                          fetch_valid;
  logic                          rd_bank;
  logic [video_pkg::H_W-3:0]     rd_addr;
  logic [video_pkg::BEAT_W-1:0]  rd_data;
  video_pkg::rgb888_t            color;

  assign video_mode_out = video_mode;

  apb_regs i_apb_regs (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
    .video_mode, .show_graphic, .graphic_base
  );

  video_timing i_video_timing (
    .clk, .reset, .video_mode, .h_count, .v_count, .de, .hsync, .vsync,
    .line_start, .fetch_line, .fetch_valid
  );

  line_fetch #(
    .LINE_BUF_DEPTH  (LINE_BUF_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_line_fetch (
    .clk, .reset, .show_graphic, .graphic_base, .video_mode,
    .line_start, .fetch_line, .fetch_valid,
    .a_valid, .a_source, .a_address, .a_ready,
    .d_valid, .d_source, .d_data,
    .rd_bank, .rd_addr, .rd_data
  );

  pixel_pipe i_pixel_pipe (
    .clk, .reset, .h_count, .v_count, .show_graphic,
    .rd_bank, .rd_addr, .rd_data, .color
  );

  tmds_encoder i_enc_red (
    .clk, .reset, .data(color.red), .ctrl(2'b00), .de, .sym(tmds_red)
  );

  tmds_encoder i_enc_green (
    .clk, .reset, .data(color.green), .ctrl(2'b00), .de, .sym(tmds_green)
  );

  // Sync rides on the blue lane
  tmds_encoder i_enc_blue (
    .clk, .reset, .data(color.blue), .ctrl({vsync, hsync}), .de, .sym(tmds_blue)
  );

endmodule

//--- sim/video_assertions.sv
module video_assertions #(
  parameter int MAX_OUTSTANDING = 4
) (
  input logic                               clk,
  input logic                               reset,
  input logic                               a_valid,
  input logic                               a_ready,
  input logic [1:0]                         a_source,
  input logic [31:0]                        a_address,
  input logic                               d_valid,
  input logic [1:0]                         d_source,
  input logic                               line_start,
  input logic [$clog2(MAX_OUTSTANDING+1)-1:0] open_count,
  input logic [3:0]                         src_busy,
  input logic [1:0]                         state
);

  // Request held until accepted
  a_stable: assert property (@(posedge clk) disable iff (reset)
    a_valid && !a_ready |=> a_valid && $stable(a_address) && $stable(a_source))
    else $error("request changed while stalled");

  a_open_limit: assert property (@(posedge clk) disable iff (reset)
    open_count <= MAX_OUTSTANDING)
    else $error("too many open requests");

  a_known_source: assert property (@(posedge clk) disable iff (reset)
    d_valid |-> src_busy[d_source])
    else $error("response for a source with no open request");

  // Idle state encodes as 0, a busy fetcher here means a stale line
  a_fetch_done: assert property (@(posedge clk) disable iff (reset)
    line_start |-> state == 2'd0)
    else $error("line fetch still running at next line start");

endmodule

bind line_fetch video_assertions #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_video_assertions (
  .clk(clk), .reset(reset), .a_valid(a_valid), .a_ready(a_ready),
  .a_source(a_source), .a_address(a_address), .d_valid(d_valid), .d_source(d_source),
  .line_start(line_start), .open_count(open_count), .src_busy(src_busy), .state(state)
);

//--- sim/tb_video.sv
module tb_video;

  localparam int TIMEOUT_CYCLES = 3 * 800 * 525 + 240_000; // Three 640x480 frames plus margin
  localparam video_pkg::tmds_sym_t CTRL_00 = 10'b1101010100;

  logic                         clk = 1'b0;
  logic                         reset;
  logic [4:0]                   paddr;
  logic                         psel, penable, pwrite;
  logic [31:0]                  pwdata, prdata;
  logic                         a_valid, a_ready;
  logic [1:0]                   a_source;
  logic [31:0]                  a_address;
  logic                         d_valid;
  logic [1:0]                   d_source;
  logic [63:0]                  d_data;
  video_pkg::tmds_sym_t         tmds_red, tmds_green, tmds_blue;
  video_pkg::video_mode_e       video_mode_out;

  int          cycles = 0;
  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] lfsr = 32'hda0867f0;
  logic        bp_on = 1'b0;
  logic        model_reset, model_bp;
  logic [31:0] pend_addr[$];
  logic [1:0]  pend_src[$];
  int          pend_due[$];
  logic [31:0] req_log[$];
  logic        resp_busy = 1'b0;
  logic [31:0] cur_addr;
  int          beat;
  logic        is_ctrl;   // Latest sample from the TMDS stream
  logic [1:0]  sync;
  video_pkg::rgb888_t pix;
  int          vs_syms, runs_at_vs;

  video_top #(.LINE_BUF_DEPTH(512), .MAX_OUTSTANDING(4)) i_dut (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
    .a_valid, .a_ready, .a_source, .a_address, .d_valid, .d_source, .d_data,
    .tmds_red, .tmds_green, .tmds_blue, .video_mode_out
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit
  function automatic logic take_bit();
    logic b;
    b = lfsr[0];
    lfsr = b ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
    return b;
  endfunction

  function automatic logic [15:0] pixel_at(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e3779b1;
    return h[31:16] ^ addr[16:1];
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] addr);
    logic [63:0] d;
    for (int i = 0; i < 4; i++)
      d[16*i +: 16] = pixel_at(addr + 32'(2 * i)); // Lowest pixel in low bits
    return d;
  endfunction

  function automatic video_pkg::rgb888_t expand565(input logic [15:0] p);
    video_pkg::rgb888_t c;
    c.red   = {p[15:11], p[15:13]};
    c.green = {p[10:5], p[10:9]};
    c.blue  = {p[4:0], p[4:2]};
    return c;
  endfunction

  function automatic logic decode_sym(input video_pkg::tmds_sym_t s, output logic [1:0] ctrl,
                                      output logic [7:0] data);
    logic [7:0] q;
    ctrl = 2'b00;
    data = 8'h00;
    case (s)
      10'b1101010100: ctrl = 2'b00;
      10'b0010101011: ctrl = 2'b01;
      10'b0101010100: ctrl = 2'b10;
      10'b1010101011: ctrl = 2'b11;
      default: begin
        q = s[9] ? ~s[7:0] : s[7:0];
        data[0] = q[0];
        for (int i = 1; i < 8; i++)
          data[i] = s[8] ? q[i] ^ q[i-1] : ~(q[i] ^ q[i-1]);
        return 1'b0;
      end
    endcase
    return 1'b1;
  endfunction

  // Source still owned by a queued or streaming burst
  function automatic logic source_in_use(input logic [1:0] src);
    if (d_valid && d_source == src)
      return 1'b1;
    foreach (pend_src[i])
      if (pend_src[i] == src)
        return 1'b1;
    return 1'b0;
  endfunction

  // Memory model captures requests mid-cycle
  always @(negedge clk) begin
    if (!reset && a_valid && a_ready) begin
      if (source_in_use(a_source))
        report_error($sformatf("request reuses source %0d while it is still open", a_source));
      pend_addr.push_back(a_address);
      pend_src.push_back(a_source);
      pend_due.push_back(cycles + 3);
      req_log.push_back(a_address);
    end
  end

  always @(posedge clk) begin
    model_reset = reset;
    model_bp = bp_on;
    #10;
    if (model_reset) begin
      pend_addr.delete();
      pend_src.delete();
      pend_due.delete();
      resp_busy = 1'b0;
      a_ready = 1'b1;
      d_valid = 1'b0;
    end else begin
      a_ready = 1'b1;
      if (model_bp)
        a_ready = take_bit() | take_bit(); // Low about one cycle in four
      if (!resp_busy && pend_addr.size() > 0 && pend_due[0] <= cycles) begin
        cur_addr = pend_addr.pop_front();
        d_source = pend_src.pop_front();
        void'(pend_due.pop_front());
        resp_busy = 1'b1;
        beat = 0;
      end
      d_valid = resp_busy;
      if (resp_busy) begin
        d_data = beat_data(cur_addr + 32'(8 * beat));
        beat++;
        if (beat == 8)
          resp_busy = 1'b0;
      end
    end
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("Error: %s", msg);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected address %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_mode(input string name, input video_pkg::video_mode_e exp,
                            input video_pkg::video_mode_e act);
    if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_color(input string name, input video_pkg::rgb888_t exp,
                             input video_pkg::rgb888_t act);
    if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("PASS: %s", name);
    end else begin
      tests_failed++;
      $display("FAIL: %s (%0d errors)", name, error_count - errs_before);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #10 reset = 1'b1;
    bp_on = 1'b0;
    repeat (4) @(posedge clk);
    #10 reset = 1'b0;
    req_log.delete();
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    #10;
    paddr = addr;
    psel = 1'b1;
    pwrite = 1'b1;
    pwdata = data;
    @(posedge clk);
    #10 penable = 1'b1;
    @(posedge clk);
    #10;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(posedge clk);
    #10;
    paddr = addr;
    psel = 1'b1;
    pwrite = 1'b0;
    @(posedge clk);
    #10 penable = 1'b1;
    @(negedge clk);
    data = prdata;
    @(posedge clk);
    #10;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic next_sym();
    logic [1:0] c_r, c_g;
    logic [7:0] r, g, b;
    @(negedge clk);
    void'(decode_sym(tmds_red, c_r, r));
    void'(decode_sym(tmds_green, c_g, g));
    is_ctrl = decode_sym(tmds_blue, sync, b);
    pix = {r, g, b};
  endtask

  // Walks the stream until the data run after n_lines complete runs begins
  task automatic scan_lines(input int n_lines, input int active, input int period,
                            input int hs_len, input logic check_pix, input logic [31:0] base);
    int runs, run_len, hs_run, last_hs, t;
    logic in_data, hs_prev;
    logic [31:0] addr;
    video_pkg::rgb888_t exp;
    runs = 0;
    run_len = 0;
    hs_run = 0;
    last_hs = -1;
    t = 0;
    in_data = 1'b0;
    hs_prev = 1'b0;
    vs_syms = 0;
    runs_at_vs = -1;
    while (1) begin
      next_sym();
      if (!is_ctrl) begin
        if (!in_data && runs == n_lines)
          break;
        in_data = 1'b1;
        addr = base + 32'(runs) * 32'd4096 + 32'(run_len) * 32'd2;
        exp = check_pix ? expand565(pixel_at(addr)) : '0;
        if (!check_pix || runs == 1 || runs == 2 || runs == n_lines / 2 || runs == n_lines - 1)
          check_color($sformatf("line %0d pixel %0d", runs, run_len), exp, pix);
        run_len++;
      end else begin
        if (in_data) begin
          check_word($sformatf("line %0d data run", runs), 32'(active), 32'(run_len));
          runs++;
          run_len = 0;
          in_data = 1'b0;
        end
        if (sync[0]) begin
          if (!hs_prev && last_hs >= 0)
            check_word("hsync period", 32'(period), 32'(t - last_hs));
          if (!hs_prev)
            last_hs = t;
          hs_run++;
        end else if (hs_prev) begin
          check_word("hsync length", 32'(hs_len), 32'(hs_run));
          hs_run = 0;
        end
        hs_prev = sync[0];
        if (sync[1]) begin
          vs_syms++;
          if (runs_at_vs < 0)
            runs_at_vs = runs;
        end
      end
      t++;
    end
  endtask

  task automatic register_access();
    int errs;
    logic [31:0] rd;
    errs = error_count;
    apply_reset();
    apb_write(5'h04, 32'h12345678);
    apb_read(5'h04, rd);
    check_word("base readback", 32'h12345640, rd);
    apb_write(5'h00, 32'h0000_0006);
    apb_read(5'h00, rd);
    check_word("control readback", 32'h0000_0006, rd);
    check_mode("mode output", video_pkg::mode_1024x768, video_mode_out);
    apb_write(5'h00, 32'h0000_0003);
    apb_read(5'h00, rd);
    check_word("control readback 2", 32'h0000_0003, rd);
    check_mode("mode output 2", video_pkg::mode_1280x720, video_mode_out);
    finish_test("register access", errs);
  endtask

  task automatic idle_output();
    int errs;
    errs = error_count;
    apply_reset();
    repeat (2000) begin
      next_sym();
      check_word("red idle symbol", 32'(CTRL_00), 32'(tmds_red));
      check_word("green idle symbol", 32'(CTRL_00), 32'(tmds_green));
      check_word("blue idle symbol", 32'(CTRL_00), 32'(tmds_blue));
      if (a_valid)
        report_error("request issued while video is off");
    end
    finish_test("mode off", errs);
  endtask

  task automatic timing_640x480();
    int errs;
    errs = error_count;
    apply_reset();
    apb_write(5'h00, 32'h0000_0001);
    scan_lines(480, 640, 800, 96, 1'b0, 32'h0);
    check_word("vsync symbols", 32'd1600, 32'(vs_syms));
    check_word("lines before vsync", 32'd480, 32'(runs_at_vs));
    finish_test("640x480 timing", errs);
  endtask

  task automatic check_requests(input logic [31:0] base, input int bursts, input int lines);
    if (req_log.size() < bursts * lines) begin
      report_error($sformatf("only %0d requests seen", req_log.size()));
    end else begin
      for (int i = 0; i < bursts * lines; i++)
        check_addr($sformatf("request %0d", i),
                   base + 32'(1 + i / bursts) * 32'd4096 + 32'(i % bursts) * 32'd64,
                   req_log[i]);
    end
  endtask

  task automatic fetch_backpressure();
    int errs;
    errs = error_count;
    apply_reset();
    bp_on = 1'b1;
    apb_write(5'h04, 32'h0123_4000);
    apb_write(5'h00, 32'h0000_0005);
    scan_lines(6, 640, 800, 96, 1'b1, 32'h0123_4000);
    check_requests(32'h0123_4000, 20, 5); // Line 0 is never fetched in the first frame
    finish_test("fetch with back-pressure", errs);
  endtask

  task automatic pixel_content();
    int errs;
    errs = error_count;
    apply_reset();
    apb_write(5'h04, 32'h0040_0000);
    apb_write(5'h00, 32'h0000_0005);
    scan_lines(480, 640, 800, 96, 1'b1, 32'h0040_0000);
    finish_test("640x480 pixel content", errs);
  endtask

  task automatic lines_720p();
    int errs;
    errs = error_count;
    apply_reset();
    bp_on = 1'b1;
    apb_write(5'h04, 32'h0200_0000);
    apb_write(5'h00, 32'h0000_0007);
    scan_lines(3, 1280, 1650, 40, 1'b1, 32'h0200_0000);
    check_requests(32'h0200_0000, 40, 2);
    finish_test("1280x720", errs);
  endtask

  initial begin
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    a_ready = 1'b1;
    d_valid = 1'b0;
    d_source = '0;
    d_data = '0;
    register_access();
    idle_output();
    timing_640x480();
    fetch_backpressure();
    pixel_content();
    lines_720p();
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- flist.f
design/video_pkg.sv
design/apb_regs.sv
design/video_timing.sv
design/line_fetch.sv
design/pixel_pipe.sv
design/tmds_encoder.sv
design/video_top.sv
sim/video_assertions.sv
sim/tb_video.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

obj_dir/Vtb_video: flist.f $(wildcard design/*.sv sim/*.sv)
	verilator --binary --timing --assert --top-module tb_video -f flist.f

test: obj_dir/Vtb_video
	./obj_dir/Vtb_video > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
